// File: telemetry_xclk.f
+incdir+src
+incdir+verification
src/xclk_pkg.sv
src/telemetry_pkg.sv
src/reset_sync.sv
src/bit_sync.sv
src/gray_counter.sv
src/event_counter.sv
src/ss2cc.sv
src/telemetry_xclk_top.sv
verification/telemetry_xclk_tb.sv

// File: verification/telemetry_xclk_tests.svh
// Directed crossing tests

// ----------------------------------------------------------------------
// reset helpers
// ----------------------------------------------------------------------

// both outputs must read zero while in or just out of reset
task automatic expect_outputs_zero(input string phase);
  assert (clkb_link_status == '0) else begin
    $display("error: clkb_link_status is 0x%h %s, expected 0x0", clkb_link_status, phase);
    errors++;
  end
  assert (clkb_event_count == '0) else begin
    $display("error: clkb_event_count is 0x%h %s, expected 0x0", clkb_event_count, phase);
    errors++;
  end
endtask

// reset is held low for 3 clka cycles with quiet inputs
// the outputs stay zero until the first real transfer
task automatic apply_reset();
  int i;
  cnt_chk_en = 1'b0;
  @(posedge clka);
  clka_rst_n       <= 1'b0;
  clka_event       <= 1'b0;
  clka_link_status <= '0;
  pulses_sent = 0;
  repeat (3) @(posedge clka);
  expect_outputs_zero("during reset");
  clka_rst_n <= 1'b1;
  for (i = 0; i < 16; i++) begin
    @(posedge clkb);
    expect_outputs_zero("after reset release");
  end
  // both rings are running by now
  repeat (4) @(posedge clka);
endtask

// ----------------------------------------------------------------------
// link status tests
// ----------------------------------------------------------------------

// drives a value and waits until the output shows it
task automatic settle_status(input link_status_t value);
  int waited;
  @(posedge clka);
  clka_link_status <= value;
  waited = 0;
  while (clkb_link_status !== value && waited < 20) begin
    @(posedge clkb);
    waited++;
  end
  assert (clkb_link_status === value) else begin
    $display("clkb_link_status did not settle to the baseline value in time");
    errors++;
  end
endtask

// a new distinct status every clka cycle, each must arrive once and in order
task automatic drive_ordered_sequence(input int n, input int offset);
  link_status_t sent[$];
  link_status_t v;
  int i;
  int waited;
  settle_status('0);
  status_q.delete();
  for (i = 0; i < n; i++) begin
    @(posedge clka);
    v = link_status_t'(15'(4096 + i * 131 + offset));
    clka_link_status <= v;
    sent.push_back(v);
  end
  waited = 0;
  while (status_q.size() < n && waited < n + 40) begin
    @(posedge clka);
    waited++;
  end
  // extra cycles expose any late duplicate
  repeat (10) @(posedge clka);
  assert (status_q.size() == n) else begin
    $display("ordered delivery saw %0d output changes instead of %0d", status_q.size(), n);
    errors++;
  end
  for (i = 0; i < n && i < status_q.size(); i++) begin
    assert (status_q[i] == sent[i]) else begin
      $display("error: clkb_link_status change %0d is 0x%h, expected 0x%h",
               i, status_q[i], sent[i]);
      errors++;
    end
  end
endtask

// a held level shows up within 7 clkb cycles of being sampled and then stays
task automatic hold_status_level(input link_status_t value, input int hold);
  int hold_end;
  int waited;
  @(posedge clka);
  clka_link_status <= value;
  hold_end = cycle_cnt + hold;
  // the DUT samples the new level on this edge
  @(posedge clka);
  waited = 0;
  while (clkb_link_status !== value && waited < 7) begin
    @(posedge clkb);
    waited++;
  end
  assert (clkb_link_status == value) else begin
    $display("error: clkb_link_status is 0x%h after 7 clkb cycles, expected 0x%h",
             clkb_link_status, value);
    errors++;
  end
  while (cycle_cnt < hold_end) begin
    @(posedge clkb);
    assert (clkb_link_status == value) else begin
      $display("error: clkb_link_status moved to 0x%h during hold of 0x%h",
               clkb_link_status, value);
      errors++;
    end
  end
endtask

// ----------------------------------------------------------------------
// event count tests
// ----------------------------------------------------------------------

// random pulses, then idle time so the last count step can cross
task automatic count_random_events(input int cycles);
  logic [31:0] r;
  event_count_t expected;
  int i;
  cnt_chk_en = 1'b1;
  for (i = 0; i < cycles; i++) begin
    @(posedge clka);
    r = $random(seed);
    clka_event <= r[0];
    if (r[0]) begin
      pulses_sent++;
    end
  end
  @(posedge clka);
  clka_event <= 1'b0;
  repeat (20) @(posedge clka);
  // the count wraps at its width, the same as a cast of the pulse total
  expected = event_count_t'(pulses_sent);
  @(posedge clkb);
  assert (clkb_event_count == expected) else begin
    $display("error: clkb_event_count is 0x%h, expected 0x%h", clkb_event_count, expected);
    errors++;
  end
endtask

// reset in the middle of status changes and pulses
task automatic reset_during_traffic();
  logic [31:0] r;
  int i;
  cnt_chk_en = 1'b0;
  for (i = 0; i < 30; i++) begin
    @(posedge clka);
    r = $random(seed);
    clka_link_status <= link_status_t'(r[14:0]);
    clka_event       <= r[15];
  end
  apply_reset();
endtask

// File: verification/telemetry_xclk_tb.sv
// Telemetry crossing testbench
`timescale 1ns/1ps

module telemetry_xclk_tb;

  import telemetry_pkg::*;

  // run limit in clka cycles
  // all tests together take about 900 clka cycles, so this leaves a wide margin
  localparam int timeout_cycles = 2000;

  // DUT ports
  logic         clka;
  logic         clkb;
  logic         clka_rst_n;
  link_status_t clka_link_status;
  logic         clka_event;
  link_status_t clkb_link_status;
  event_count_t clkb_event_count;

  // bookkeeping shared by the monitors and the tests
  int           errors = 0;
  int           cycle_cnt = 0;
  int           pulses_sent = 0;
  integer       seed = 62553;
  logic         cnt_chk_en = 1'b0;
  link_status_t status_prev;
  event_count_t count_prev;
  link_status_t status_q[$];

  // ----------------------------------------------------------------------
  // clocks and DUT
  // ----------------------------------------------------------------------

  // clka rises at 5, 15, 25 ns and clkb at 3.5, 10.5, 17.5 ns
  // so the edges of the two clocks never meet
  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;
  end

  initial begin
    clkb = 1'b0;
    forever #3.5 clkb = ~clkb;
  end

  telemetry_xclk_top i_dut (
    .clka             (clka),
    .clka_rst_n       (clka_rst_n),
    .clkb             (clkb),
    .clka_link_status (clka_link_status),
    .clka_event       (clka_event),
    .clkb_link_status (clkb_link_status),
    .clkb_event_count (clkb_event_count)
  );

  // ----------------------------------------------------------------------
  // clkb monitors
  // ----------------------------------------------------------------------

  // every change of the status output is recorded in arrival order
  always @(posedge clkb) begin
    if (clkb_link_status !== status_prev) begin
      status_q.push_back(clkb_link_status);
    end
    status_prev = clkb_link_status;
  end

  // while enabled, each change of the count must be a single step forward
  always @(posedge clkb) begin
    if (cnt_chk_en && clkb_event_count !== count_prev) begin
      assert (clkb_event_count == count_prev + event_count_t'(1)) else begin
        $display("error: clkb_event_count stepped from 0x%h to 0x%h",
                 count_prev, clkb_event_count);
        errors++;
      end
    end
    count_prev = clkb_event_count;
  end

  // ----------------------------------------------------------------------
  // run limit
  // ----------------------------------------------------------------------

  always @(negedge clka) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout, the run was stopped after %0d clka cycles", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  `include "telemetry_xclk_tests.svh"

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    clka_rst_n       = 1'b0;
    clka_event       = 1'b0;
    clka_link_status = '0;
    apply_reset();
    drive_ordered_sequence(200, 0);
    hold_status_level(link_status_t'(15'h2a5a), 50);
    count_random_events(300);
    // second pass after a reset in the middle of traffic
    reset_during_traffic();
    drive_ordered_sequence(50, 1);
    count_random_events(100);
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src/telemetry_xclk_top.sv
// Telemetry crossing top level
`timescale 1ns/1ps

module telemetry_xclk_top (
  input  logic                        clka,
  input  logic                        clka_rst_n,
  input  logic                        clkb,
  input  telemetry_pkg::link_status_t clka_link_status,
  input  logic                        clka_event,
  output telemetry_pkg::link_status_t clkb_link_status,
  output telemetry_pkg::event_count_t clkb_event_count
);

  import telemetry_pkg::*;

  // synchronized resets, one per clock domain
  logic clka_rst_sync_n;
  logic clkb_rst_sync_n;

  // running event count in the clka domain
  event_count_t clka_event_count;

  // ----------------------------------------------------------------------
  // resets
  // ----------------------------------------------------------------------

  // both domains leave reset on their own clock from the one raw reset
  reset_sync u_rst_a (
    .clk        (clka),
    .rst_n      (clka_rst_n),
    .rst_sync_n (clka_rst_sync_n)
  );

  reset_sync u_rst_b (
    .clk        (clkb),
    .rst_n      (clka_rst_n),
    .rst_sync_n (clkb_rst_sync_n)
  );

  // ----------------------------------------------------------------------
  // clka telemetry sources
  // ----------------------------------------------------------------------

  // turns the event pulses into a level that can be sampled each cycle
  event_counter u_evt_cnt (
    .clka        (clka),
    .clka_rst_n  (clka_rst_sync_n),
    .event_pulse (clka_event),
    .count       (clka_event_count)
  );

  // ----------------------------------------------------------------------
  // crossings into clkb
  // ----------------------------------------------------------------------

  // link status word
  ss2cc #(
    .payload_t (link_status_t)
  ) u_xclk_status (
    .clka          (clka),
    .clka_rst_n    (clka_rst_sync_n),
    .clka_data_in  (clka_link_status),
    .clkb          (clkb),
    .clkb_rst_n    (clkb_rst_sync_n),
    .clkb_data_out (clkb_link_status)
  );

  // event count, every step of the count is delivered in order
  ss2cc #(
    .payload_t (event_count_t)
  ) u_xclk_count (
    .clka          (clka),
    .clka_rst_n    (clka_rst_sync_n),
    .clka_data_in  (clka_event_count),
    .clkb          (clkb),
    .clkb_rst_n    (clkb_rst_sync_n),
    .clkb_data_out (clkb_event_count)
  );

endmodule

// File: src/ss2cc.sv
// Slot ring clock crossing
`timescale 1ns/1ps
`include "xclk_macros.svh"

module ss2cc #(
  parameter type payload_t = logic,
  parameter int depth = `XCLK_DEPTH,
  localparam int ptr_w = xclk_pkg::ptr_width(depth)
) (
  input  logic     clka,
  input  logic     clka_rst_n,
  input  payload_t clka_data_in,
  input  logic     clkb,
  input  logic     clkb_rst_n,
  output payload_t clkb_data_out
);

  import xclk_pkg::*;

  // clka side state
  logic             clka_started_f;
  logic             clka_incr_nxt;
  logic             clka_incr_f;
  slot_mask_t       clka_we_f;
  slot_mask_t       clka_we_nxt;
  payload_t         clka_slot_f [depth];
  logic [ptr_w-1:0] clka_gray;

  // clkb side state
  logic             clkb_started_f;
  logic             clkb_started_sync;
  logic [ptr_w-1:0] clka_gray_sync;
  logic [ptr_w-1:0] clkb_gray;
  logic             clkb_incr;
  slot_mask_t       clkb_re_f;
  slot_mask_t       clkb_re_nxt;
  payload_t         clkb_slot_sel;
  payload_t         clkb_data_f;

  // ----------------------------------------------------------------------
  // clka write side
  // ----------------------------------------------------------------------

  // a new slot is written on every cycle once both sides are out of reset
  assign clka_incr_nxt = clka_started_f & clkb_started_sync;

  // the write selector moves to the next slot after each write
  // from the top slot it goes back to slot 0
  always_comb begin
    clka_we_nxt = clka_we_f;
    if (clka_incr_nxt) begin
      clka_we_nxt = clka_we_f << 1;
      if (clka_we_f[depth-1]) begin
        clka_we_nxt = slot_mask_t'(1);
      end
    end
  end

  // the pointer step is delayed by one cycle against the slot write
  // so the slot is settled before the far side can see the step
  always_ff @(posedge clka or negedge clka_rst_n) begin
    if (!clka_rst_n) begin
      clka_started_f <= 1'b0;
      clka_incr_f    <= 1'b0;
      clka_we_f      <= slot_mask_t'(1);
    end else begin
      clka_started_f <= 1'b1;
      clka_incr_f    <= clka_incr_nxt;
      clka_we_f      <= clka_we_nxt;
    end
  end

  // slot storage, loaded only in the slot under the write selector
  always_ff @(posedge clka) begin
    for (int i = 0; i < depth; i++) begin
      if (clka_incr_nxt && clka_we_f[i]) begin
        clka_slot_f[i] <= clka_data_in;
      end
    end
  end

  // write pointer in gray code, one step per written slot
  gray_counter #(
    .width (ptr_w)
  ) u_gray_a (
    .clk   (clka),
    .rst_n (clka_rst_n),
    .incr  (clka_incr_f),
    .gray  (clka_gray)
  );

  // the clkb started flag is brought into clka before any write starts
  bit_sync #(
    .width (1)
  ) u_sync_started (
    .clk       (clka),
    .rst_n     (clka_rst_n),
    .data      (clkb_started_f),
    .data_sync (clkb_started_sync)
  );

  // ----------------------------------------------------------------------
  // clkb read side
  // ----------------------------------------------------------------------

  // write pointer seen from clkb
  bit_sync #(
    .width (ptr_w)
  ) u_sync_gray (
    .clk       (clkb),
    .rst_n     (clkb_rst_n),
    .data      (clka_gray),
    .data_sync (clka_gray_sync)
  );

  // a pointer mismatch means one more slot is ready to read
  // clkb is at least as fast as clka, so the reader never falls a ring behind
  assign clkb_incr = (clka_gray_sync != clkb_gray);

  // read pointer in gray code, kept in step with the read selector
  gray_counter #(
    .width (ptr_w)
  ) u_gray_b (
    .clk   (clkb),
    .rst_n (clkb_rst_n),
    .incr  (clkb_incr),
    .gray  (clkb_gray)
  );

  // the slot data is read straight from the clka registers
  // it has been stable since before its pointer step entered the synchronizer
  always_comb begin
    clkb_slot_sel = '0;
    for (int i = 0; i < depth; i++) begin
      if (clkb_re_f[i]) begin
        clkb_slot_sel = clka_slot_f[i];
      end
    end
  end

  // the read selector rotates like the write selector, once per read
  always_comb begin
    clkb_re_nxt = clkb_re_f;
    if (clkb_incr) begin
      clkb_re_nxt = clkb_re_f << 1;
      if (clkb_re_f[depth-1]) begin
        clkb_re_nxt = slot_mask_t'(1);
      end
    end
  end

  // the output loads once per read, so each sample lands exactly once
  always_ff @(posedge clkb or negedge clkb_rst_n) begin
    if (!clkb_rst_n) begin
      clkb_started_f <= 1'b0;
      clkb_re_f      <= slot_mask_t'(1);
      clkb_data_f    <= '0;
    end else begin
      clkb_started_f <= 1'b1;
      clkb_re_f      <= clkb_re_nxt;
      if (clkb_incr) begin
        clkb_data_f <= clkb_slot_sel;
      end
    end
  end

  assign clkb_data_out = clkb_data_f;

endmodule

// File: src/event_counter.sv
// Event pulse counter
`timescale 1ns/1ps

module event_counter (
  input  logic                        clka,
  input  logic                        clka_rst_n,
  input  logic                        event_pulse,
  output telemetry_pkg::event_count_t count
);

  import telemetry_pkg::*;

  // one count for one pulse
  localparam event_count_t one = event_count_t'(1);

  // ----------------------------------------------------------------------
  // running count
  // ----------------------------------------------------------------------

  // each pulse lasts one clka cycle and is counted once
  // the new value shows up one clka cycle after the pulse
  // the count wraps to zero after its largest value
  always_ff @(posedge clka or negedge clka_rst_n) begin
    if (!clka_rst_n) begin
      count <= '0;
    end else if (event_pulse) begin
      count <= count + one;
    end
  end

  // the count is a level in the clka domain
  // the crossing samples it every cycle, so every step reaches the far side

endmodule

// File: src/gray_counter.sv
// Gray-coded counter
`timescale 1ns/1ps
`include "xclk_macros.svh"

module gray_counter #(
  parameter int width = xclk_pkg::ptr_width(`XCLK_DEPTH)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             incr,
  output logic [width-1:0] gray
);

  // binary form of the count, kept locally for the addition
  logic [width-1:0] bin_f;
  logic [width-1:0] bin_nxt;

  // ----------------------------------------------------------------------
  // next count
  // ----------------------------------------------------------------------

  // the count moves by one on a strobe and wraps at the width
  always_comb begin
    bin_nxt = bin_f;
    if (incr) begin
      bin_nxt = bin_f + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  // the gray output is registered from the next count
  // so it changes on the same edge as the binary count, with no glitch
  // only one output bit differs between two neighbouring counts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin_f <= '0;
      gray  <= '0;
    end else begin
      bin_f <= bin_nxt;
      gray  <= bin_nxt ^ (bin_nxt >> 1);
    end
  end

endmodule

// File: src/bit_sync.sv
// Multi-flop bit synchronizer
`timescale 1ns/1ps
`include "xclk_macros.svh"

module bit_sync #(
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] data,
  output logic [width-1:0] data_sync
);

  // ----------------------------------------------------------------------
  // metastability chain
  // ----------------------------------------------------------------------

  // stage 0 captures the foreign signal, later stages let it settle
  logic [`XCLK_SYNC_STAGES-1:0][width-1:0] stage_f;

  // every bit has its own chain of flops
  // a multi-bit input must be gray coded so only one bit moves at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_f <= '0;
    end else begin
      stage_f[0] <= data;
      for (int i = 1; i < `XCLK_SYNC_STAGES; i++) begin
        stage_f[i] <= stage_f[i-1];
      end
    end
  end

  // ----------------------------------------------------------------------
  // output
  // ----------------------------------------------------------------------

  // the last stage is safe to use in the local domain
  assign data_sync = stage_f[`XCLK_SYNC_STAGES-1];

endmodule

// File: src/reset_sync.sv
// Reset synchronizer
`timescale 1ns/1ps
`include "xclk_macros.svh"

module reset_sync (
  input  logic clk,
  input  logic rst_n,
  output logic rst_sync_n
);

  // shift chain that is cleared by the raw reset and fills with ones
  logic [`XCLK_SYNC_STAGES-1:0] chain_f;

  // assertion reaches the output at once through the asynchronous clear
  // release walks through the chain, so the output deasserts on a clock edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chain_f <= '0;
    end else begin
      // a one enters at the bottom and moves up one flop per edge
      chain_f <= {chain_f[`XCLK_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // the last flop of the chain is the synchronized reset
  assign rst_sync_n = chain_f[`XCLK_SYNC_STAGES-1];

endmodule

// File: src/telemetry_pkg.sv
// Telemetry payload package
`include "xclk_macros.svh"

package telemetry_pkg;

  // ----------------------------------------------------------------------
  // link status word
  // ----------------------------------------------------------------------

  // status of the link as seen in the source domain
  // it is a level and is sampled on every source clock edge
  typedef struct packed {
    // link is trained and passing traffic
    logic       link_up;
    // encoded line rate
    logic [1:0] speed;
    // number of active lanes
    logic [3:0] lane_count;
    // sticky error indications, one bit per error class
    logic [7:0] err_flags;
  } link_status_t;

  // ----------------------------------------------------------------------
  // event count
  // ----------------------------------------------------------------------

  // unsigned running count of event pulses
  // it wraps silently at its width
  typedef logic [`EVT_CNT_W-1:0] event_count_t;

endpackage

// File: src/xclk_pkg.sv
// Crossing mechanics package
`include "xclk_macros.svh"

package xclk_pkg;

  // ----------------------------------------------------------------------
  // pointer sizing
  // ----------------------------------------------------------------------

  // width of a gray pointer that can tell the slots of a ring apart
  // this is the ceiling of log2 of the ring depth
  function automatic int ptr_width(input int depth);
    int w;
    w = 0;
    // grow the width until two to that power covers every slot
    while ((1 << w) < depth) begin
      w++;
    end
    return w;
  endfunction

  // ----------------------------------------------------------------------
  // slot selection
  // ----------------------------------------------------------------------

  // one-hot selector over the ring slots
  // exactly one bit is set at any time, and it rotates one place per step
  typedef logic [`XCLK_DEPTH-1:0] slot_mask_t;

endpackage

// File: src/xclk_macros.svh
// Crossing build constants
`ifndef XCLK_MACROS_SVH
`define XCLK_MACROS_SVH

// ----------------------------------------------------------------------
// slot ring sizing
// ----------------------------------------------------------------------

// number of data slots in every crossing ring
// three is the smallest depth that keeps a slot stable while it is read
`define XCLK_DEPTH 4

// ----------------------------------------------------------------------
// synchronizer and payload sizing
// ----------------------------------------------------------------------

// flops in every metastability chain and in every reset synchronizer
`define XCLK_SYNC_STAGES 2

// width of the wrapping event count carried across the crossing
`define EVT_CNT_W 16

`endif
